//--- hw/pi1_defs.svh
// pi1 subsystem defines
`ifndef PI1_DEFS_SVH
`define PI1_DEFS_SVH

// bus data width in bits
`define PI1_ARCHBITSZ 32

// word address width, byte offset bits dropped
`define PI1_ADDRBITSZ 30

// one select bit per data byte
`define PI1_SELBITSZ 4

// serial device, two words at byte 0xff8
// word 0 is the data register, word 1 the status register
`define PI1_SER_BASE 30'h3fe

// ram starts right after the serial device, byte 0x1000
`define PI1_MEM_BASE 30'h400

// ram depth in words, 4 KB
`define PI1_MEM_WORDS 1024

// extra cycles the ram holds rdy low after each access
`define PI1_MEM_DELAY 2

// entries in each serial byte queue
`define PI1_QUEUE_DEPTH 16

`endif

//--- hw/pi1_pkg.sv
// pi1 bus types
`default_nettype none

package pi1_pkg;

	// bus operation encoding
	// nop leaves the slave idle
	// wr writes the selected byte lanes
	// rd returns the whole word
	// rw swaps, old word back and new word in
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11
	} pi1_op_t;

	// slave index used by the router
	// invalid is the catch-all for unmapped addresses
	typedef enum logic [1:0] {
		SLV_SERIAL  = 2'd0,
		SLV_RAM     = 2'd1,
		SLV_INVALID = 2'd2
	} pi1_slave_t;

endpackage

`default_nettype wire

//--- hw/byte_queue.sv
// byte fifo
`timescale 1ns/1ps
`default_nettype none

module byte_queue #(
	 parameter int DEPTH = 16
) (
	 input  wire                           clk_i
	,input  wire                           rst_i
	,input  wire                           push_i
	,input  wire  [7:0]                    push_data_i
	,input  wire                           pop_i
	,output logic [7:0]                    pop_data_o
	,output logic [$clog2(DEPTH+1)-1:0]    count_o
	,output logic                          full_o
	,output logic                          empty_o
);

	// pointer width, at least one bit
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	// count runs 0..DEPTH inclusive
	localparam int CW = $clog2(DEPTH + 1);

	logic [7:0]    buf_q [DEPTH];
	logic [PW-1:0] wr_ptr_q;
	logic [PW-1:0] rd_ptr_q;
	logic [CW-1:0] count_q;
	logic          do_push;
	logic          do_pop;

	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == CW'(DEPTH));
	assign count_o = count_q;

	// head byte is visible before the pop
	assign pop_data_o = buf_q[rd_ptr_q];

	// a pop on a full queue makes room for a push in the same cycle
	assign do_pop  = pop_i && !empty_o;
	assign do_push = push_i && (!full_o || do_pop);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			// pointers wrap at DEPTH, not at a power of two
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop && !do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk_i) begin
		if (do_push) begin
			buf_q[wr_ptr_q] <= push_data_i;
		end
	end

	// the user must not overrun the queue
	a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
		(push_i && full_o) |-> pop_i);

	// nor pop it when it holds nothing
	a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- hw/pi1_serial.sv
// pi1 serial device
`timescale 1ns/1ps
`default_nettype none

`include "pi1_defs.svh"

module pi1_serial import pi1_pkg::*; (
	 input  wire                          clk_i
	,input  wire                          rst_i
	,input  wire pi1_op_t                 pi1_op_i
	,input  wire                          pi1_addr_i
	,input  wire  [`PI1_ARCHBITSZ-1:0]    pi1_data_i
	,output logic [`PI1_ARCHBITSZ-1:0]    pi1_data_o
	,input  wire  [`PI1_SELBITSZ-1:0]     pi1_sel_i
	,output logic                         pi1_rdy_o
	,output logic [7:0]                   tx_data_o
	,output logic                         tx_stb_o
	,input  wire                          tx_busy_i
	,input  wire  [7:0]                   rx_data_i
	,input  wire                          rx_stb_i
);

	localparam int QDEPTH = `PI1_QUEUE_DEPTH;
	localparam int CW     = $clog2(QDEPTH + 1);
	// status word halves
	localparam int HW     = `PI1_ARCHBITSZ / 2;

	// register index inside the device
	localparam logic REG_DATA   = 1'b0;
	localparam logic REG_STATUS = 1'b1;

	logic                      accept;
	logic                      is_read;
	logic                      tx_req;
	logic                      tx_push;
	logic [7:0]                tx_push_data;
	logic                      tx_pop;
	logic [CW-1:0]             tx_count;
	logic [CW-1:0]             tx_free;
	logic                      tx_full;
	logic                      tx_empty;
	logic                      rx_push;
	logic                      rx_pop;
	logic [7:0]                rx_head;
	logic [CW-1:0]             rx_count;
	logic                      rx_full;
	logic                      rx_empty;
	logic [`PI1_ARCHBITSZ-1:0] rd_word;
	logic                      pend_q;
	logic [7:0]                pend_data_q;
	logic [`PI1_ARCHBITSZ-1:0] data_q;

	// only a parked write stalls the bus
	assign pi1_rdy_o = !pend_q;
	assign accept    = (pi1_op_i != PI1_NOP) && pi1_rdy_o;
	// swap behaves as a plain read here
	assign is_read   = (pi1_op_i == PI1_RD) || (pi1_op_i == PI1_RW);

	// byte lane 0 written to the data register
	assign tx_req = accept && (pi1_op_i == PI1_WR) && (pi1_addr_i == REG_DATA)
		&& pi1_sel_i[0];

	// one byte leaves per cycle while the line is free
	assign tx_pop    = !tx_empty && !tx_busy_i;
	assign tx_stb_o  = tx_pop;

	// a parked byte goes first, new writes cannot arrive while it waits
	assign tx_push      = (tx_req || pend_q) && (!tx_full || tx_pop);
	assign tx_push_data = pend_q ? pend_data_q : pi1_data_i[7:0];
	assign tx_free      = CW'(QDEPTH) - tx_count;

	// incoming bytes are dropped once the queue is full
	assign rx_push = rx_stb_i && !rx_full;
	assign rx_pop  = accept && is_read && (pi1_addr_i == REG_DATA) && !rx_empty;

	// read word, zero for writes and for an empty receive queue
	always_comb begin
		rd_word = '0;
		if (is_read) begin
			if (pi1_addr_i == REG_STATUS) begin
				rd_word[HW +: HW] = HW'(rx_count);
				rd_word[HW-1:0]   = HW'(tx_free);
			end else if (!rx_empty) begin
				// bit 8 flags a valid byte
				rd_word[8]   = 1'b1;
				rd_word[7:0] = rx_head;
			end
		end
	end

	// pending write when the transmit queue had no room
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q <= 1'b0;
		end else if (tx_req && !tx_push) begin
			pend_q <= 1'b1;
		end else if (pend_q && tx_push) begin
			pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (tx_req) begin
			pend_data_q <= pi1_data_i[7:0];
		end
	end

	// response lands one cycle after acceptance
	always_ff @(posedge clk_i) begin
		if (accept) begin
			data_q <= rd_word;
		end
	end

	assign pi1_data_o = data_q;

	byte_queue #(
		 .DEPTH (QDEPTH)
	) tx_queue (
		 .clk_i       (clk_i)
		,.rst_i       (rst_i)
		,.push_i      (tx_push)
		,.push_data_i (tx_push_data)
		,.pop_i       (tx_pop)
		,.pop_data_o  (tx_data_o)
		,.count_o     (tx_count)
		,.full_o      (tx_full)
		,.empty_o     (tx_empty)
	);

	byte_queue #(
		 .DEPTH (QDEPTH)
	) rx_queue (
		 .clk_i       (clk_i)
		,.rst_i       (rst_i)
		,.push_i      (rx_push)
		,.push_data_i (rx_data_i)
		,.pop_i       (rx_pop)
		,.pop_data_o  (rx_head)
		,.count_o     (rx_count)
		,.full_o      (rx_full)
		,.empty_o     (rx_empty)
	);

	// a parked write drains as soon as the line frees
	a_pend_drains: assert property (@(posedge clk_i) disable iff (rst_i)
		(pend_q && !tx_busy_i) |=> !pend_q);

endmodule

`default_nettype wire

//--- hw/pi1_smem.sv
// pi1 ram slave
`timescale 1ns/1ps
`default_nettype none

`include "pi1_defs.svh"

module pi1_smem import pi1_pkg::*; #(
	 parameter int WORDS = 1024
	,parameter int DELAY = 0
) (
	 input  wire                          clk_i
	,input  wire                          rst_i
	,input  wire pi1_op_t                 pi1_op_i
	,input  wire  [$clog2(WORDS)-1:0]     pi1_addr_i
	,input  wire  [`PI1_ARCHBITSZ-1:0]    pi1_data_i
	,output logic [`PI1_ARCHBITSZ-1:0]    pi1_data_o
	,input  wire  [`PI1_SELBITSZ-1:0]     pi1_sel_i
	,output logic                         pi1_rdy_o
);

	// counter needs at least one bit even without delay
	localparam int CNTW = (DELAY > 0) ? $clog2(DELAY + 1) : 1;

	logic [`PI1_ARCHBITSZ-1:0] mem_q [WORDS];
	logic [`PI1_ARCHBITSZ-1:0] data_q;
	logic [CNTW-1:0]           cnt_q;
	logic                      accept;
	logic                      do_rd;
	logic                      do_wr;

	// ready whenever the delay count has run out
	assign pi1_rdy_o = (cnt_q == '0);
	assign accept    = (pi1_op_i != PI1_NOP) && pi1_rdy_o;
	// swap both reads and writes
	assign do_rd     = accept && ((pi1_op_i == PI1_RD) || (pi1_op_i == PI1_RW));
	assign do_wr     = accept && ((pi1_op_i == PI1_WR) || (pi1_op_i == PI1_RW));

	// rdy low for DELAY cycles after every access
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else if (accept) begin
			cnt_q <= CNTW'(DELAY);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// per-byte write, old word is read out on the same edge for swap
	always_ff @(posedge clk_i) begin
		if (do_wr) begin
			for (int i = 0; i < `PI1_SELBITSZ; i++) begin
				if (pi1_sel_i[i]) begin
					mem_q[pi1_addr_i][i*8 +: 8] <= pi1_data_i[i*8 +: 8];
				end
			end
		end
		if (do_rd) begin
			data_q <= mem_q[pi1_addr_i];
		end
	end

	assign pi1_data_o = data_q;

	// an op waiting on a busy ram keeps its address
	a_addr_held: assert property (@(posedge clk_i) disable iff (rst_i)
		(!pi1_rdy_o && (pi1_op_i != PI1_NOP)) ##1 (!pi1_rdy_o && (pi1_op_i != PI1_NOP))
		|-> $stable(pi1_addr_i));

endmodule

`default_nettype wire

//--- hw/pi1_router.sv
// pi1 address router
`timescale 1ns/1ps
`default_nettype none

`include "pi1_defs.svh"

module pi1_router import pi1_pkg::*; (
	 input  wire                                clk_i
	,input  wire                                rst_i
	,input  wire pi1_op_t                       m_op_i
	,input  wire  [`PI1_ADDRBITSZ-1:0]          m_addr_i
	,input  wire  [`PI1_ARCHBITSZ-1:0]          m_data_i
	,input  wire  [`PI1_SELBITSZ-1:0]           m_sel_i
	,output logic [`PI1_ARCHBITSZ-1:0]          m_data_o
	,output logic                               m_rdy_o
	,output pi1_op_t                            ser_op_o
	,output logic                               ser_addr_o
	,output logic [`PI1_ARCHBITSZ-1:0]          ser_data_o
	,output logic [`PI1_SELBITSZ-1:0]           ser_sel_o
	,input  wire  [`PI1_ARCHBITSZ-1:0]          ser_data_i
	,input  wire                                ser_rdy_i
	,output pi1_op_t                            mem_op_o
	,output logic [$clog2(`PI1_MEM_WORDS)-1:0]  mem_addr_o
	,output logic [`PI1_ARCHBITSZ-1:0]          mem_data_o
	,output logic [`PI1_SELBITSZ-1:0]           mem_sel_o
	,input  wire  [`PI1_ARCHBITSZ-1:0]          mem_data_i
	,input  wire                                mem_rdy_i
);

	localparam int MAW = $clog2(`PI1_MEM_WORDS);

	logic [`PI1_ADDRBITSZ-1:0] ser_off;
	logic [`PI1_ADDRBITSZ-1:0] mem_off;
	pi1_slave_t                dec;
	pi1_slave_t                resp_q;
	logic                      fwd_en;
	logic                      accept;

	// addresses rebased to each slave
	assign ser_off = m_addr_i - `PI1_SER_BASE;
	assign mem_off = m_addr_i - `PI1_MEM_BASE;

	// fixed map, anything unmapped falls to the invalid device
	always_comb begin
		if (ser_off < `PI1_ADDRBITSZ'(2)) begin
			dec = SLV_SERIAL;
		end else if ((m_addr_i >= `PI1_MEM_BASE)
			&& (mem_off < `PI1_ADDRBITSZ'(`PI1_MEM_WORDS))) begin
			dec = SLV_RAM;
		end else begin
			dec = SLV_INVALID;
		end
	end

	// response mux follows the slave hit by the last accepted op
	always_comb begin
		case (resp_q)
			SLV_SERIAL: begin
				m_rdy_o  = ser_rdy_i;
				m_data_o = ser_data_i;
			end
			SLV_RAM: begin
				m_rdy_o  = mem_rdy_i;
				m_data_o = mem_data_i;
			end
			default: begin
				// invalid device reads zero and never stalls
				m_rdy_o  = 1'b1;
				m_data_o = '0;
			end
		endcase
	end

	// while one slave is busy, an op for another slave is held back
	// the busy slave itself sees its op and ignores it until ready
	assign fwd_en = m_rdy_o || (dec == resp_q);
	assign accept = (m_op_i != PI1_NOP) && m_rdy_o;

	assign ser_op_o   = (fwd_en && (dec == SLV_SERIAL)) ? m_op_i : PI1_NOP;
	assign ser_addr_o = ser_off[0];
	assign ser_data_o = m_data_i;
	assign ser_sel_o  = m_sel_i;

	assign mem_op_o   = (fwd_en && (dec == SLV_RAM)) ? m_op_i : PI1_NOP;
	assign mem_addr_o = mem_off[MAW-1:0];
	assign mem_data_o = m_data_i;
	assign mem_sel_o  = m_sel_i;

	// responding slave, invalid after reset so rdy starts high
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			resp_q <= SLV_INVALID;
		end else if (accept) begin
			resp_q <= dec;
		end
	end

	// an accepted ram op is also taken by the ram
	a_ram_takes: assert property (@(posedge clk_i) disable iff (rst_i)
		(accept && (dec == SLV_RAM)) |-> mem_rdy_i);

endmodule

`default_nettype wire

//--- hw/pi1_soc.sv
// pi1 subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "pi1_defs.svh"

module pi1_soc import pi1_pkg::*; (
	 input  wire                          clk_i
	,input  wire                          rst_i
	,input  wire pi1_op_t                 pi1_op_i
	,input  wire  [`PI1_ADDRBITSZ-1:0]    pi1_addr_i
	,input  wire  [`PI1_ARCHBITSZ-1:0]    pi1_data_i
	,input  wire  [`PI1_SELBITSZ-1:0]     pi1_sel_i
	,output logic [`PI1_ARCHBITSZ-1:0]    pi1_data_o
	,output logic                         pi1_rdy_o
	,output logic [7:0]                   tx_data_o
	,output logic                         tx_stb_o
	,input  wire                          tx_busy_i
	,input  wire  [7:0]                   rx_data_i
	,input  wire                          rx_stb_i
);

	// serial slave port
	pi1_op_t                           ser_op_w;
	logic                              ser_addr_w;
	logic [`PI1_ARCHBITSZ-1:0]         ser_wdata_w;
	logic [`PI1_SELBITSZ-1:0]          ser_sel_w;
	logic [`PI1_ARCHBITSZ-1:0]         ser_rdata_w;
	logic                              ser_rdy_w;

	// ram slave port
	pi1_op_t                           mem_op_w;
	logic [$clog2(`PI1_MEM_WORDS)-1:0] mem_addr_w;
	logic [`PI1_ARCHBITSZ-1:0]         mem_wdata_w;
	logic [`PI1_SELBITSZ-1:0]          mem_sel_w;
	logic [`PI1_ARCHBITSZ-1:0]         mem_rdata_w;
	logic                              mem_rdy_w;

	pi1_router router (
		 .clk_i      (clk_i)
		,.rst_i      (rst_i)
		,.m_op_i     (pi1_op_i)
		,.m_addr_i   (pi1_addr_i)
		,.m_data_i   (pi1_data_i)
		,.m_sel_i    (pi1_sel_i)
		,.m_data_o   (pi1_data_o)
		,.m_rdy_o    (pi1_rdy_o)
		,.ser_op_o   (ser_op_w)
		,.ser_addr_o (ser_addr_w)
		,.ser_data_o (ser_wdata_w)
		,.ser_sel_o  (ser_sel_w)
		,.ser_data_i (ser_rdata_w)
		,.ser_rdy_i  (ser_rdy_w)
		,.mem_op_o   (mem_op_w)
		,.mem_addr_o (mem_addr_w)
		,.mem_data_o (mem_wdata_w)
		,.mem_sel_o  (mem_sel_w)
		,.mem_data_i (mem_rdata_w)
		,.mem_rdy_i  (mem_rdy_w)
	);

	// 4 KB ram right after the serial registers
	pi1_smem #(
		 .WORDS (`PI1_MEM_WORDS)
		,.DELAY (`PI1_MEM_DELAY)
	) smem (
		 .clk_i      (clk_i)
		,.rst_i      (rst_i)
		,.pi1_op_i   (mem_op_w)
		,.pi1_addr_i (mem_addr_w)
		,.pi1_data_i (mem_wdata_w)
		,.pi1_data_o (mem_rdata_w)
		,.pi1_sel_i  (mem_sel_w)
		,.pi1_rdy_o  (mem_rdy_w)
	);

	pi1_serial serial (
		 .clk_i      (clk_i)
		,.rst_i      (rst_i)
		,.pi1_op_i   (ser_op_w)
		,.pi1_addr_i (ser_addr_w)
		,.pi1_data_i (ser_wdata_w)
		,.pi1_data_o (ser_rdata_w)
		,.pi1_sel_i  (ser_sel_w)
		,.pi1_rdy_o  (ser_rdy_w)
		,.tx_data_o  (tx_data_o)
		,.tx_stb_o   (tx_stb_o)
		,.tx_busy_i  (tx_busy_i)
		,.rx_data_i  (rx_data_i)
		,.rx_stb_i   (rx_stb_i)
	);

endmodule

`default_nettype wire

//--- test/tb_pi1_soc.sv
// pi1 subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "pi1_defs.svh"

module tb_pi1_soc import pi1_pkg::*; ();

	localparam int QD     = `PI1_QUEUE_DEPTH;
	localparam int MAW    = $clog2(`PI1_MEM_WORDS);
	// ram words touched by the random tests
	localparam int MEM_N  = 24;
	// unmapped addresses probed
	localparam int INV_N  = 8;
	// bytes sent with a randomly busy line
	localparam int TX_N   = 10;
	// cycles the 17th write is held while the line stays busy
	localparam int HOLD_N = 6;
	localparam int RX_A   = 5;
	// more than the receive queue holds, the rest is dropped
	localparam int RX_B   = 20;
	// worst case cycles of one bus operation, ram delay plus issue and response
	localparam int OP_CYC = `PI1_MEM_DELAY + 2;
	// operations of all tests summed, each counted at the worst case
	localparam int WORST  = 16 + OP_CYC * (4 * MEM_N + 2 + 2 * INV_N + MEM_N + 3 * TX_N
		+ 2 * (QD + 1) + 2 + HOLD_N + RX_A + RX_B + RX_A + QD + 6);
	localparam int LIMIT  = 10 * WORST;

	localparam logic [`PI1_ADDRBITSZ-1:0] SER_DATA = `PI1_SER_BASE;
	localparam logic [`PI1_ADDRBITSZ-1:0] SER_STAT = `PI1_SER_BASE + 1;

	logic                       clk_i;
	logic                       rst_i;
	pi1_op_t                    pi1_op_i;
	logic [`PI1_ADDRBITSZ-1:0]  pi1_addr_i;
	logic [`PI1_ARCHBITSZ-1:0]  pi1_data_i;
	logic [`PI1_SELBITSZ-1:0]   pi1_sel_i;
	logic [`PI1_ARCHBITSZ-1:0]  pi1_data_o;
	logic                       pi1_rdy_o;
	logic [7:0]                 tx_data_o;
	logic                       tx_stb_o;
	logic                       tx_busy_i;
	logic [7:0]                 rx_data_i;
	logic                       rx_stb_i;

	// reference state
	logic [`PI1_ARCHBITSZ-1:0]  ref_mem [`PI1_MEM_WORDS];
	logic [MAW-1:0]             mem_idx [MEM_N];
	logic [7:0]                 tx_expect [$];
	logic [7:0]                 rx_expect [$];

	logic [31:0]                lfsr_q = 32'hc5cc_6ad5;
	int                         errors = 0;
	int                         checks = 0;
	int                         cycles = 0;
	// phase flags for the concurrent checks
	logic                       inv_phase = 1'b0;
	logic                       hold_phase = 1'b0;

	pi1_soc dut0 (
		 .clk_i      (clk_i)
		,.rst_i      (rst_i)
		,.pi1_op_i   (pi1_op_i)
		,.pi1_addr_i (pi1_addr_i)
		,.pi1_data_i (pi1_data_i)
		,.pi1_sel_i  (pi1_sel_i)
		,.pi1_data_o (pi1_data_o)
		,.pi1_rdy_o  (pi1_rdy_o)
		,.tx_data_o  (tx_data_o)
		,.tx_stb_o   (tx_stb_o)
		,.tx_busy_i  (tx_busy_i)
		,.rx_data_i  (rx_data_i)
		,.rx_stb_i   (rx_stb_i)
	);

	// 40 ns period
	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	// only the selected byte lanes take the new data
	function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] m;
		m = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				m[i*8 +: 8] = new_w[i*8 +: 8];
			end
		end
		return m;
	endfunction

	// receive fill count high, transmit free count low
	function automatic logic [31:0] status_word(input int rx_fill, input int tx_free);
		return {rx_fill[15:0], tx_free[15:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// drive an op at a falling edge and return once it has been accepted
	task automatic bus_issue(input pi1_op_t op, input logic [`PI1_ADDRBITSZ-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = wdata;
		pi1_sel_i  = sel;
		// rdy does not depend on op, so it is settled here
		while (!pi1_rdy_o) begin
			@(negedge clk_i);
		end
		@(negedge clk_i);
		pi1_op_i = PI1_NOP;
	endtask

	// data is taken on the first rdy-high cycle after acceptance
	task automatic bus_finish(output logic [31:0] rdata, output int stalls);
		stalls = 0;
		while (!pi1_rdy_o) begin
			stalls++;
			@(negedge clk_i);
		end
		rdata = pi1_data_o;
	endtask

	task automatic bus_op(input pi1_op_t op, input logic [`PI1_ADDRBITSZ-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel,
		output logic [31:0] rdata, output int stalls);
		bus_issue(op, addr, wdata, sel);
		bus_finish(rdata, stalls);
	endtask

	task automatic rx_pulse(input logic [7:0] b);
		rx_data_i = b;
		rx_stb_i  = 1'b1;
		// a full receive queue loses the byte
		if (rx_expect.size() < QD) begin
			rx_expect.push_back(b);
		end
		@(negedge clk_i);
		rx_stb_i = 1'b0;
	endtask

	// read every expected byte, then one more read must find the queue empty
	task automatic read_rx_bytes();
		logic [31:0] rd;
		logic [7:0]  b;
		int          st;
		while (rx_expect.size() != 0) begin
			b = rx_expect.pop_front();
			bus_op(PI1_RD, SER_DATA, '0, 4'hf, rd, st);
			check_value("pi1_data_o", rd, {23'd0, 1'b1, b});
		end
		bus_op(PI1_RD, SER_DATA, '0, 4'hf, rd, st);
		check_value("pi1_data_o", rd, '0);
	endtask

	task automatic wait_tx_drain();
		while (tx_expect.size() != 0) begin
			@(negedge clk_i);
		end
	endtask

	task automatic check_status(input int rx_fill, input int tx_free);
		logic [31:0] rd;
		int          st;
		bus_op(PI1_RD, SER_STAT, '0, 4'hf, rd, st);
		check_value("pi1_data_o", rd, status_word(rx_fill, tx_free));
	endtask

	// each strobe must carry the oldest byte still expected
	always @(posedge clk_i) begin
		logic [7:0] exp_b;
		if (!rst_i && tx_stb_o) begin
			assert (tx_expect.size() != 0) else begin
				errors++;
				$display("tx strobe at %0t with byte %h but no byte was queued",
					$time, tx_data_o);
			end
			if (tx_expect.size() != 0) begin
				exp_b = tx_expect.pop_front();
				check_value("tx_data_o", tx_data_o, exp_b);
			end
		end
	end

	a_no_stb_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		tx_stb_o |-> !tx_busy_i) else begin
		errors++;
		$display("tx strobe at %0t while the line was busy", $time);
	end

	// the invalid device never stalls
	a_invalid_rdy: assert property (@(posedge clk_i) disable iff (rst_i)
		inv_phase |-> pi1_rdy_o) else begin
		errors++;
		$display("rdy dropped at %0t during an unmapped access", $time);
	end

	// the 17th write waits as long as the line stays busy
	a_hold_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		hold_phase |-> !pi1_rdy_o) else begin
		errors++;
		$display("rdy rose at %0t with the transmit queue still full", $time);
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("run stopped after %0d cycles without finishing", LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		logic [`PI1_ARCHBITSZ-1:0] rd;
		logic [`PI1_ARCHBITSZ-1:0] wd;
		logic [`PI1_ARCHBITSZ-1:0] old;
		logic [`PI1_SELBITSZ-1:0]  sel;
		logic [`PI1_ADDRBITSZ-1:0] addr;
		int                        st;

		rst_i      = 1'b1;
		pi1_op_i   = PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		tx_busy_i  = 1'b0;
		rx_data_i  = '0;
		rx_stb_i   = 1'b0;
		repeat (16) @(negedge clk_i);
		rst_i = 1'b0;
		@(negedge clk_i);

		// idle after reset, both queues empty
		check_value("pi1_rdy_o", pi1_rdy_o, 1);
		check_value("tx_stb_o", tx_stb_o, 0);
		check_status(0, QD);

		// full words first so every later read is defined
		for (int i = 0; i < MEM_N; i++) begin
			mem_idx[i] = rand_bits(MAW);
			wd = rand_bits(32);
			bus_op(PI1_WR, `PI1_MEM_BASE + mem_idx[i], wd, 4'hf, rd, st);
			ref_mem[mem_idx[i]] = wd;
			check_value("rdy low cycles", st, `PI1_MEM_DELAY);
		end
		// then random lanes, two passes
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < MEM_N; i++) begin
				sel = rand_bits(4);
				wd = rand_bits(32);
				bus_op(PI1_WR, `PI1_MEM_BASE + mem_idx[i], wd, sel, rd, st);
				ref_mem[mem_idx[i]] = merge_lanes(ref_mem[mem_idx[i]], wd, sel);
			end
		end
		for (int i = 0; i < MEM_N; i++) begin
			bus_op(PI1_RD, `PI1_MEM_BASE + mem_idx[i], '0, 4'hf, rd, st);
			check_value("pi1_data_o", rd, ref_mem[mem_idx[i]]);
			check_value("rdy low cycles", st, `PI1_MEM_DELAY);
		end

		// swap gives the old word back
		old = ref_mem[mem_idx[1]];
		wd = rand_bits(32);
		bus_op(PI1_RW, `PI1_MEM_BASE + mem_idx[1], wd, 4'hf, rd, st);
		check_value("pi1_data_o", rd, old);
		ref_mem[mem_idx[1]] = wd;
		bus_op(PI1_RD, `PI1_MEM_BASE + mem_idx[1], '0, 4'hf, rd, st);
		check_value("pi1_data_o", rd, wd);

		// unmapped space, edges of the map and an alias of a ram word
		inv_phase = 1'b1;
		for (int i = 0; i < INV_N; i++) begin
			case (i)
				0: addr = '0;
				1: addr = `PI1_SER_BASE - 1;
				2: addr = `PI1_MEM_BASE + `PI1_MEM_WORDS + mem_idx[0];
				3: addr = '1;
				default: addr = rand_bits(`PI1_ADDRBITSZ) | 30'h1000;
			endcase
			bus_op(PI1_WR, addr, rand_bits(32), 4'hf, rd, st);
			check_value("rdy low cycles", st, 0);
			bus_op(PI1_RD, addr, '0, 4'hf, rd, st);
			check_value("pi1_data_o", rd, '0);
			check_value("rdy low cycles", st, 0);
		end
		inv_phase = 1'b0;
		for (int i = 0; i < MEM_N; i++) begin
			bus_op(PI1_RD, `PI1_MEM_BASE + mem_idx[i], '0, 4'hf, rd, st);
			check_value("pi1_data_o", rd, ref_mem[mem_idx[i]]);
		end

		// transmit with the line going busy at random
		for (int i = 0; i < TX_N; i++) begin
			tx_busy_i = rand_bits(1);
			wd = rand_bits(32);
			// lane 0 unselected on one write, no byte is sent
			sel = (i == 3) ? 4'he : 4'hf;
			if (sel[0]) begin
				tx_expect.push_back(wd[7:0]);
			end
			bus_op(PI1_WR, SER_DATA, wd, sel, rd, st);
			check_value("rdy low cycles", st, 0);
		end
		tx_busy_i = 1'b0;
		wait_tx_drain();
		repeat (4) @(negedge clk_i);

		// fill the transmit queue behind a busy line
		tx_busy_i = 1'b1;
		for (int i = 0; i < QD; i++) begin
			wd = rand_bits(32);
			tx_expect.push_back(wd[7:0]);
			bus_op(PI1_WR, SER_DATA, wd, 4'hf, rd, st);
			check_value("rdy low cycles", st, 0);
		end
		check_status(0, 0);
		wd = rand_bits(32);
		tx_expect.push_back(wd[7:0]);
		bus_issue(PI1_WR, SER_DATA, wd, 4'hf);
		hold_phase = 1'b1;
		repeat (HOLD_N) @(negedge clk_i);
		hold_phase = 1'b0;
		tx_busy_i = 1'b0;
		bus_finish(rd, st);
		wait_tx_drain();
		check_status(0, QD);

		// receive a few bytes, then overrun the queue
		for (int i = 0; i < RX_A; i++) begin
			rx_pulse(rand_bits(8));
		end
		check_status(rx_expect.size(), QD);
		read_rx_bytes();
		for (int i = 0; i < RX_B; i++) begin
			rx_pulse(rand_bits(8));
		end
		check_status(rx_expect.size(), QD);
		read_rx_bytes();
		repeat (4) @(negedge clk_i);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/pi1_pkg.sv
hw/byte_queue.sv
hw/pi1_serial.sv
hw/pi1_smem.sv
hw/pi1_router.sv
hw/pi1_soc.sv
test/tb_pi1_soc.sv

//--- Bender.yml
package:
  name: pi1_soc

export_include_dirs:
  - hw

sources:
  - hw/pi1_pkg.sv
  - hw/byte_queue.sv
  - hw/pi1_serial.sv
  - hw/pi1_smem.sv
  - hw/pi1_router.sv
  - hw/pi1_soc.sv
  - target: test
    files:
      - test/tb_pi1_soc.sv
